// ==== Makefile ====
# Verilator flow for the scratchpad memory tile

VERILATOR  ?= verilator
TOP        ?= spm_tile_tb
FILELIST   ?= sim.f
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "No pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/spm_bank_array.sv ====
//////////////////////////////////////////////////
// Banked SRAM array
// Word-interleaved banks in rows, with a registered
// bank and row select for the read mux
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spm_bank_array
  import spm_pkg::*;
#(
  parameter int unsigned NumBanks     = 2,
  parameter int unsigned NumRows      = 4,
  parameter int unsigned WordsPerBank = 256
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  spm_access_t          access_i,
  output logic [DataWidth-1:0] rdata_o
);

  localparam int unsigned BankW = (NumBanks > 1) ? $clog2(NumBanks) : 1;
  localparam int unsigned RowW  = (NumRows > 1) ? $clog2(NumRows) : 1;
  localparam int unsigned WordW = $clog2(WordsPerBank);

  logic [NumRows-1:0][NumBanks-1:0][DataWidth-1:0] sram_rdata;

  logic             rd_q;
  logic [BankW-1:0] bank_q;
  logic [RowW-1:0]  row_q;

  // One macro per bank and row, only the addressed one is enabled
  for (genvar r = 0; r < NumRows; r++) begin : gen_row
    for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
      spm_sram #(
        .WordsPerBank(WordsPerBank)
      ) i_sram (
        .clk_i  (clk_i),
        .req_i  (access_i.en && (access_i.bank == BankIdxWidth'(b))
                 && (access_i.row == RowIdxWidth'(r))),
        .we_i   (access_i.we),
        .addr_i (access_i.word[WordW-1:0]),
        .wdata_i(access_i.wdata),
        .be_i   (access_i.strb),
        .rdata_o(sram_rdata[r][b])
      );
    end
  end

  // Read pending flag for the returning data
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= access_i.en & ~access_i.we;
    end
  end

  // Select follows the access into the next cycle
  always_ff @(posedge clk_i) begin
    if (access_i.en) begin
      bank_q <= access_i.bank[BankW-1:0];
      row_q  <= access_i.row[RowW-1:0];
    end
  end

  assign rdata_o = rd_q ? sram_rdata[row_q][bank_q] : '0;

endmodule

`default_nettype wire

// ==== design/spm_ctrl.sv ====
//////////////////////////////////////////////////
// Scratchpad access control
// Admits requests against response credits,
// splits the address and tracks the access stage
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spm_ctrl
  import spm_pkg::*;
#(
  parameter int unsigned NumBanks     = 2,
  parameter int unsigned NumRows      = 4,
  parameter int unsigned WordsPerBank = 256,
  parameter int unsigned RspDepth     = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           in_valid_i,
  input  spm_req_t                       in_req_i,
  input  logic                           in_atomic_i,
  output logic                           in_ready_o,
  output spm_access_t                    access_o,
  input  logic [$clog2(RspDepth+1)-1:0]  rsp_count_i,
  output logic                           push_o,
  output logic [IdWidth-1:0]             push_id_o,
  output logic                           push_read_o,
  output logic                           push_err_o
);

  localparam int unsigned CountWidth   = $clog2(RspDepth + 1);
  localparam int unsigned ByteOffWidth = $clog2(StrbWidth);
  localparam int unsigned WordAddrW    = AddrWidth - ByteOffWidth;
  // Words in one row of banks
  localparam int unsigned RowStride    = NumBanks * WordsPerBank;

  logic [WordAddrW-1:0]  word_addr;
  logic [CountWidth:0]   credits_used;
  logic                  accept;

  // Stage register, one entry per accepted request
  logic                  stage_valid_q;
  logic [IdWidth-1:0]    stage_id_q;
  logic                  stage_read_q;
  logic                  stage_err_q;

  // Buffered responses plus the one in flight must leave a free slot
  assign credits_used = {1'b0, rsp_count_i} + (CountWidth + 1)'(stage_valid_q);
  assign in_ready_o   = (credits_used < RspDepth);
  assign accept       = in_valid_i & in_ready_o;

  //////////////////////////////////////////////////
  // Address split, bank bits sit above the byte offset
  //////////////////////////////////////////////////
  assign word_addr = in_req_i.addr[AddrWidth-1:ByteOffWidth];

  always_comb begin
    access_o.en    = accept & ~in_atomic_i;
    access_o.we    = (in_req_i.op == SPM_OP_WRITE);
    access_o.bank  = BankIdxWidth'(word_addr % NumBanks);
    access_o.word  = WordIdxWidth'((word_addr / NumBanks) % WordsPerBank);
    access_o.row   = RowIdxWidth'(word_addr / RowStride);
    access_o.wdata = in_req_i.wdata;
    access_o.strb  = in_req_i.strb;
  end

  //////////////////////////////////////////////////
  // Access stage
  //////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      stage_valid_q <= 1'b0;
    end else begin
      stage_valid_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      stage_id_q   <= in_req_i.id;
      stage_read_q <= (in_req_i.op == SPM_OP_READ) & ~in_atomic_i;
      stage_err_q  <= in_atomic_i;
    end
  end

  assign push_o      = stage_valid_q;
  assign push_id_o   = stage_id_q;
  assign push_read_o = stage_read_q;
  assign push_err_o  = stage_err_q;

endmodule

`default_nettype wire

// ==== design/spm_pkg.sv ====
//////////////////////////////////////////////////
// Scratchpad memory tile shared definitions
// Word widths, operation kinds and the request,
// response and bank-access records of the tile
//////////////////////////////////////////////////

`default_nettype none

package spm_pkg;

  // Word and link widths
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned AddrWidth = 13;
  localparam int unsigned IdWidth   = 4;

  // Maximum index widths of a bank access
  localparam int unsigned BankIdxWidth = 2;
  localparam int unsigned RowIdxWidth  = 3;
  localparam int unsigned WordIdxWidth = 10;

  typedef enum logic [1:0] {
    SPM_OP_READ   = 2'd0,
    SPM_OP_WRITE  = 2'd1,
    SPM_OP_ATOMIC = 2'd2
  } spm_op_e;

  typedef struct packed {
    spm_op_e                op;
    logic [AddrWidth-1:0]   addr;
    logic [DataWidth-1:0]   wdata;
    logic [StrbWidth-1:0]   strb;
    logic [IdWidth-1:0]     id;
  } spm_req_t;

  // Read data is zero for writes and errors
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } spm_rsp_t;

  typedef struct packed {
    logic                    en;
    logic                    we;
    logic [BankIdxWidth-1:0] bank;
    logic [RowIdxWidth-1:0]  row;
    logic [WordIdxWidth-1:0] word;
    logic [DataWidth-1:0]    wdata;
    logic [StrbWidth-1:0]    strb;
  } spm_access_t;

endpackage

`default_nettype wire

// ==== design/spm_req_filter.sv ====
//////////////////////////////////////////////////
// Request filter
// Flags operations the SRAM cannot execute so
// that they return an error response
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spm_req_filter
  import spm_pkg::*;
(
  input  logic     req_valid_i,
  input  spm_req_t req_i,
  output logic     req_ready_o,
  output logic     fwd_valid_o,
  output spm_req_t fwd_req_o,
  output logic     fwd_atomic_o,
  input  logic     fwd_ready_i
);

  logic is_mem_op;

  // Only plain reads and writes reach the banks
  always_comb begin
    case (req_i.op)
      SPM_OP_READ:  is_mem_op = 1'b1;
      SPM_OP_WRITE: is_mem_op = 1'b1;
      default:      is_mem_op = 1'b0;
    endcase
  end

  // Handshake passes straight through
  assign fwd_valid_o = req_valid_i;
  assign req_ready_o = fwd_ready_i;

  // Anything that is not a memory op is answered as an atomic
  assign fwd_atomic_o = ~is_mem_op;

  // Op is kept as is, the strobe of a flagged request is cleared
  always_comb begin
    fwd_req_o = req_i;
    if (!is_mem_op) begin
      fwd_req_o.strb = '0;
    end
  end

endmodule

`default_nettype wire

// ==== design/spm_rsp_buffer.sv ====
//////////////////////////////////////////////////
// Response buffer
// In-order FIFO that holds responses while the
// consumer stalls
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spm_rsp_buffer
  import spm_pkg::*;
#(
  parameter int unsigned RspDepth = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          push_i,
  input  spm_rsp_t                      push_rsp_i,
  output logic [$clog2(RspDepth+1)-1:0] count_o,
  output logic                          rsp_valid_o,
  output spm_rsp_t                      rsp_o,
  input  logic                          rsp_ready_i
);

  localparam int unsigned PtrW = (RspDepth > 1) ? $clog2(RspDepth) : 1;

  spm_rsp_t        mem [RspDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic            pop;

  assign rsp_valid_o = (count_o != '0);
  assign rsp_o       = mem[rd_ptr_q];
  assign pop         = rsp_valid_o & rsp_ready_i;

  // Control never pushes into a full buffer
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_rsp_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_o  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(RspDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(RspDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push_i && !pop) begin
        count_o <= count_o + 1'b1;
      end else if (pop && !push_i) begin
        count_o <= count_o - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/spm_sram.sv ====
//////////////////////////////////////////////////
// Single-port SRAM
// Byte-masked write, read data one cycle later
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spm_sram
  import spm_pkg::*;
#(
  parameter int unsigned WordsPerBank = 256
) (
  input  logic                            clk_i,
  input  logic                            req_i,
  input  logic                            we_i,
  input  logic [$clog2(WordsPerBank)-1:0] addr_i,
  input  logic [DataWidth-1:0]            wdata_i,
  input  logic [StrbWidth-1:0]            be_i,
  output logic [DataWidth-1:0]            rdata_o
);

  logic [DataWidth-1:0] mem [WordsPerBank];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int i = 0; i < StrbWidth; i++) begin
          if (be_i[i]) begin
            mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/spm_tile.sv ====
//////////////////////////////////////////////////
// Scratchpad memory tile
// Filter, access control, banked SRAM and the
// in-order response buffer on one request link
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spm_tile
  import spm_pkg::*;
#(
  parameter int unsigned NumBanks     = 2,
  parameter int unsigned NumRows      = 4,
  parameter int unsigned WordsPerBank = 256,
  parameter int unsigned RspDepth     = 4
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_valid_i,
  input  spm_req_t req_i,
  output logic     req_ready_o,
  output logic     rsp_valid_o,
  output spm_rsp_t rsp_o,
  input  logic     rsp_ready_i
);

  logic                          fwd_valid;
  spm_req_t                      fwd_req;
  logic                          fwd_atomic;
  logic                          fwd_ready;
  spm_access_t                   access;
  logic [DataWidth-1:0]          bank_rdata;
  logic [$clog2(RspDepth+1)-1:0] rsp_count;
  logic                          push;
  logic [IdWidth-1:0]            push_id;
  logic                          push_read;
  logic                          push_err;
  spm_rsp_t                      push_rsp;

  spm_req_filter i_filter (
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .fwd_valid_o (fwd_valid),
    .fwd_req_o   (fwd_req),
    .fwd_atomic_o(fwd_atomic),
    .fwd_ready_i (fwd_ready)
  );

  spm_ctrl #(
    .NumBanks    (NumBanks),
    .NumRows     (NumRows),
    .WordsPerBank(WordsPerBank),
    .RspDepth    (RspDepth)
  ) i_ctrl (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_valid_i (fwd_valid),
    .in_req_i   (fwd_req),
    .in_atomic_i(fwd_atomic),
    .in_ready_o (fwd_ready),
    .access_o   (access),
    .rsp_count_i(rsp_count),
    .push_o     (push),
    .push_id_o  (push_id),
    .push_read_o(push_read),
    .push_err_o (push_err)
  );

  spm_bank_array #(
    .NumBanks    (NumBanks),
    .NumRows     (NumRows),
    .WordsPerBank(WordsPerBank)
  ) i_bank_array (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .access_i(access),
    .rdata_o (bank_rdata)
  );

  // Response word, data only for successful reads
  assign push_rsp.id    = push_id;
  assign push_rsp.rdata = push_read ? bank_rdata : '0;
  assign push_rsp.err   = push_err;

  spm_rsp_buffer #(
    .RspDepth(RspDepth)
  ) i_rsp_buffer (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .push_i     (push),
    .push_rsp_i (push_rsp),
    .count_o    (rsp_count),
    .rsp_valid_o(rsp_valid_o),
    .rsp_o      (rsp_o),
    .rsp_ready_i(rsp_ready_i)
  );

endmodule

`default_nettype wire

// ==== dv/spm_tile_tb.sv ====
//////////////////////////////////////////////////
// Scratchpad tile testbench
// Table-driven requests with in-order response
// checks and random response back-pressure
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spm_tile_tb
  import spm_pkg::*;
();

  localparam int unsigned WaitLimit = 200;

  typedef struct {
    string    name;
    spm_req_t req;
    spm_rsp_t exp;
    bit       stall;
  } test_entry_t;

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  spm_req_t req;
  logic     req_ready;
  logic     rsp_valid;
  spm_rsp_t rsp;
  logic     rsp_ready;

  test_entry_t table_q[$];
  bit          stall_mode;
  int unsigned check_count;
  int unsigned error_count;

  spm_tile dut_i (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .req_valid_i(req_valid),
    .req_i      (req),
    .req_ready_o(req_ready),
    .rsp_valid_o(rsp_valid),
    .rsp_o      (rsp),
    .rsp_ready_i(rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Table construction
  //////////////////////////////////////////////////

  // For reads the data argument is the expected word
  task automatic add_entry(
    input string                name,
    input spm_op_e              op,
    input logic [AddrWidth-1:0] addr,
    input logic [DataWidth-1:0] data,
    input logic [StrbWidth-1:0] strb
  );
    test_entry_t entry;
    entry.name      = name;
    entry.req.op    = op;
    entry.req.addr  = addr;
    entry.req.wdata = (op == SPM_OP_READ) ? '0 : data;
    entry.req.strb  = (op == SPM_OP_READ) ? '0 : strb;
    entry.req.id    = IdWidth'(table_q.size() + 1);
    entry.exp.id    = entry.req.id;
    entry.exp.rdata = (op == SPM_OP_READ) ? data : '0;
    entry.exp.err   = (op == SPM_OP_ATOMIC);
    entry.stall     = stall_mode;
    table_q.push_back(entry);
  endtask

  task automatic build_table();
    stall_mode = 1'b0;
    // Base word with its bank and row neighbours
    add_entry("wr_base",         SPM_OP_WRITE,  13'h0000, 32'h1111_2222, 4'hf);
    add_entry("wr_bank1",        SPM_OP_WRITE,  13'h0004, 32'h3333_4444, 4'hf);
    add_entry("wr_row1",         SPM_OP_WRITE,  13'h0800, 32'h5555_6666, 4'hf);
    add_entry("wr_row3",         SPM_OP_WRITE,  13'h1800, 32'h7777_8888, 4'hf);
    add_entry("rd_base",         SPM_OP_READ,   13'h0000, 32'h1111_2222, 4'h0);
    add_entry("rd_bank1",        SPM_OP_READ,   13'h0004, 32'h3333_4444, 4'h0);
    add_entry("rd_row1",         SPM_OP_READ,   13'h0800, 32'h5555_6666, 4'h0);
    add_entry("rd_row3",         SPM_OP_READ,   13'h1800, 32'h7777_8888, 4'h0);
    // Bytes 0 and 2 replaced
    add_entry("wr_strb_0101",    SPM_OP_WRITE,  13'h0000, 32'haabb_ccdd, 4'b0101);
    add_entry("rd_merged",       SPM_OP_READ,   13'h0000, 32'h11bb_22dd, 4'h0);
    add_entry("amo_bank1",       SPM_OP_ATOMIC, 13'h0004, 32'hdead_beef, 4'hf);
    add_entry("rd_after_amo",    SPM_OP_READ,   13'h0004, 32'h3333_4444, 4'h0);
    stall_mode = 1'b1;
    // Top word of bank 1 in rows 1 and 3
    add_entry("bp_wr_top_row1",  SPM_OP_WRITE,  13'h0ffc, 32'hcafe_f00d, 4'hf);
    add_entry("bp_wr_top_row3",  SPM_OP_WRITE,  13'h1ffc, 32'h0bad_cafe, 4'hf);
    add_entry("bp_rd_top_row1",  SPM_OP_READ,   13'h0ffc, 32'hcafe_f00d, 4'h0);
    add_entry("bp_rd_top_row3",  SPM_OP_READ,   13'h1ffc, 32'h0bad_cafe, 4'h0);
    add_entry("bp_wr_strb_1000", SPM_OP_WRITE,  13'h0800, 32'h9900_0000, 4'b1000);
    add_entry("bp_amo_row3",     SPM_OP_ATOMIC, 13'h1800, 32'h0000_0001, 4'hf);
    add_entry("bp_rd_row1",      SPM_OP_READ,   13'h0800, 32'h9955_6666, 4'h0);
    add_entry("bp_rd_row3",      SPM_OP_READ,   13'h1800, 32'h7777_8888, 4'h0);
    add_entry("bp_rd_base",      SPM_OP_READ,   13'h0000, 32'h11bb_22dd, 4'h0);
    add_entry("bp_rd_bank1",     SPM_OP_READ,   13'h0004, 32'h3333_4444, 4'h0);
  endtask

  //////////////////////////////////////////////////
  // Checks and link tasks
  //////////////////////////////////////////////////

  task automatic check_rsp(input string name, input spm_rsp_t exp, input spm_rsp_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("error: %s expected id=%h rdata=%h err=%b actual id=%h rdata=%h err=%b",
               name, exp.id, exp.rdata, exp.err, act.id, act.rdata, act.err);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("error: %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $finish;
  endtask

  // Ready depends only on registered state, so a high sample means a transfer at the next edge
  task automatic send_req(input test_entry_t entry);
    int unsigned cycles;
    cycles    = 0;
    req_valid = 1'b1;
    req       = entry.req;
    while (!req_ready && cycles < WaitLimit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!req_ready) begin
      abort_run($sformatf("Request %s was never accepted by the tile", entry.name));
    end else begin
      @(posedge clk);
      #1;
      req_valid = 1'b0;
    end
  endtask

  task automatic recv_rsp(input test_entry_t entry);
    int unsigned cycles;
    int unsigned hold;
    cycles = 0;
    hold   = entry.stall ? ($urandom % 6) : 0;
    if (hold != 0) begin
      rsp_ready = 1'b0;
      repeat (hold) begin
        @(posedge clk);
        #1;
      end
    end
    rsp_ready = 1'b1;
    while (!rsp_valid && cycles < WaitLimit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!rsp_valid) begin
      abort_run($sformatf("No response arrived for request %s", entry.name));
    end else begin
      check_rsp(entry.name, entry.exp, rsp);
      @(posedge clk);
      #1;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req         = '0;
    rsp_ready   = 1'b0;
    check_count = 0;
    error_count = 0;
    build_table();
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    void'($urandom(9));
    check_bit("ready_after_reset", 1'b1, req_ready);
    check_bit("idle_after_reset", 1'b0, rsp_valid);
    rsp_ready = 1'b1;
    // Requests and responses run independently so several stay in flight
    fork
      begin
        foreach (table_q[i]) send_req(table_q[i]);
      end
      begin
        foreach (table_q[i]) recv_rsp(table_q[i]);
      end
    join
    // Every response taken, so nothing may be left over
    check_bit("idle_at_end", 1'b0, rsp_valid);
    check_bit("ready_at_end", 1'b1, req_ready);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
design/spm_pkg.sv
design/spm_sram.sv
design/spm_req_filter.sv
design/spm_ctrl.sv
design/spm_bank_array.sv
design/spm_rsp_buffer.sv
design/spm_tile.sv
dv/spm_tile_tb.sv
